//--- list.f
+incdir+common
common/system_pkg.sv
source/up_regs.sv
gpio/up_gpio.sv
spi/up_spi_master.sv
radio_ctrl/radio_ensm.sv
source/system_top.sv
verification/tb_clkgen.sv
verification/tb_system_top.sv

//--- Makefile
# Verilator build of the transceiver control testbench

VERILATOR ?= verilator
TOP       ?= tb_system_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR JOBS VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- verification/tb_system_top.sv
// **********************************************************
// Testbench of the control side: host stimulus, SPI slave
// loopback, reference functions, read checker, watchdog
// **********************************************************

`timescale 1ns/10ps
`include "system_defines.svh"

module tb_system_top;

  localparam int unsigned SEED = 32'hfbaf;
  localparam int CLK_DIV = `SYS_SPI_CLK_DIV;
  localparam int GUARD   = `SYS_ENSM_GUARD;
  localparam int N_GPIO  = 8;
  localparam int N_PIN   = 6;
  localparam int N_SPI   = 4;
  localparam int N_RADIO = 10;
  localparam int NUM_TESTS = 1 + N_GPIO + N_PIN + N_SPI + N_RADIO;
  // Each test gets room for one full frame plus two guard sequences
  localparam int WATCHDOG_CYCLES =
    NUM_TESTS * (2 * `SYS_SPI_FRAME_WIDTH * CLK_DIV + 4 * GUARD + 50);

  logic clk;
  logic arst_n;
  system_pkg::up_wr_t    up_wr;
  system_pkg::up_rd_t    up_rd;
  system_pkg::up_data_t  up_rdata;
  logic                  up_rack;
  logic [12:0]           bd_in;
  logic [7:0]            status_in;
  logic [7:0]            bd_out;
  logic                  resetb, sync, en_agc;
  logic [3:0]            ctl;
  logic                  csn, sclk, mosi, miso;
  logic                  enable, txnrx;
  // Model of the output register as the host has written it
  system_pkg::gpio_vec_t gpio_shadow;
  // Expected read data and the bits that matter, in issue order
  system_pkg::up_data_t  exp_q[$];
  system_pkg::up_data_t  mask_q[$];
  system_pkg::up_data_t  exp_word, mask_word;
  logic                  enable_prev, txnrx_prev;

  tb_clkgen #(.PERIOD(10), .RESET_CYCLES(3)) i_clkgen (.clk_o(clk), .arst_n_o(arst_n));

  // SPI slave model sends every bit straight back
  assign miso = mosi;

  system_top dut0 (
    .up_clk_i(clk), .arst_n_i(arst_n), .up_wr_i(up_wr), .up_rd_i(up_rd),
    .up_rdata_o(up_rdata), .up_rack_o(up_rack),
    .gpio_bd_i(bd_in), .gpio_bd_o(bd_out), .gpio_resetb_o(resetb),
    .gpio_sync_o(sync), .gpio_en_agc_o(en_agc), .gpio_ctl_o(ctl),
    .gpio_status_i(status_in), .spi_csn_o(csn), .spi_clk_o(sclk),
    .spi_mosi_o(mosi), .spi_miso_i(miso), .enable_o(enable), .txnrx_o(txnrx)
  );

  // **********************************************************
  // Reference functions
  // **********************************************************
  // Input pins on 12:0 and 39:32, everything else reads back the register
  function automatic system_pkg::gpio_vec_t expected_gpio_read(
    input system_pkg::gpio_vec_t out_reg, input logic [12:0] bd, input logic [7:0] status);
    system_pkg::gpio_vec_t v;
    v = out_reg;
    v[12:0] = bd;
    v[39:32] = status;
    return v;
  endfunction

  // resetb, sync, en_agc, ctl and bd outputs in that order
  function automatic logic [14:0] expected_pins(input system_pkg::gpio_vec_t out_reg);
    return {out_reg[46], out_reg[45], out_reg[44], out_reg[43:40], out_reg[20:13]};
  endfunction

  // With mosi looped to miso the last eight bits sampled are the frame's low byte
  function automatic logic [7:0] expected_rx_byte(input system_pkg::spi_frame_t frame);
    return frame[7:0];
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
      $display(">>> FAIL");
      $fatal(1, "%s mismatch", name);
    end
  endtask

  // **********************************************************
  // Host register port
  // **********************************************************
  task automatic write_reg(input system_pkg::up_addr_t addr, input system_pkg::up_data_t data);
    @(posedge clk);
    up_wr <= '{req: 1'b1, addr: addr, data: data};
    @(posedge clk);
    up_wr <= '0;
  endtask

  task automatic read_reg(input system_pkg::up_addr_t addr, input system_pkg::up_data_t exp,
                          input system_pkg::up_data_t mask, output system_pkg::up_data_t data);
    @(posedge clk);
    up_rd <= '{req: 1'b1, addr: addr};
    exp_q.push_back(exp);
    mask_q.push_back(mask);
    @(posedge clk);
    up_rd <= '0;
    // The acknowledge comes on the cycle right after the strobe
    @(negedge clk);
    assert (up_rack) else begin
      $display(">>> FAIL");
      $fatal(1, "No read acknowledge one cycle after the strobe to address %h", addr);
    end
    data = up_rdata;
  endtask

  // Reads all three GPIO words against the model
  task automatic check_gpio_words();
    system_pkg::gpio_vec_t exp;
    system_pkg::up_data_t  data;
    exp = expected_gpio_read(gpio_shadow, bd_in, status_in);
    for (int w = 0; w < 3; w++) begin
      read_reg(8'(w), exp[w*32 +: 32], '1, data);
    end
  endtask

  task automatic check_pins();
    check_value("board pins", 32'({resetb, sync, en_agc, ctl, bd_out}),
                32'(expected_pins(gpio_shadow)));
  endtask

  // Compare process, every acknowledge is matched with the oldest read
  always @(negedge clk) begin
    if (arst_n && up_rack) begin
      assert (exp_q.size() > 0) else begin
        $display(">>> FAIL");
        $fatal(1, "Read acknowledge without a pending read");
      end
      exp_word = exp_q.pop_front();
      mask_word = mask_q.pop_front();
      assert ((up_rdata & mask_word) === (exp_word & mask_word)) else begin
        $display("FAIL t=%0t up_rdata_o got %h expected %h", $time,
                 up_rdata & mask_word, exp_word & mask_word);
        $display(">>> FAIL");
        $fatal(1, "Register read mismatch");
      end
    end
  end

  // txnrx may only move while enable is low on both sides of the change
  always @(negedge clk) begin
    if (arst_n && (txnrx !== txnrx_prev)) begin
      assert (!enable && !enable_prev) else begin
        $display(">>> FAIL");
        $fatal(1, "txnrx_o changed while enable_o was high");
      end
    end
    enable_prev = enable;
    txnrx_prev  = txnrx;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display(">>> FAIL");
    $fatal(1, "Watchdog expired before all tests finished");
  end

  // **********************************************************
  // Test sequence
  // **********************************************************
  initial begin
    int unsigned          seed_dummy;
    int                   word, waited, polls;
    system_pkg::up_data_t data, frame_word, word1;
    system_pkg::up_addr_t addr;
    logic                 req_en, req_tx;
    seed_dummy = $urandom(SEED);
    up_wr = '0;
    up_rd = '0;
    bd_in = 13'($urandom);
    status_in = 8'($urandom);
    gpio_shadow = '0;
    @(posedge arst_n);
    @(negedge clk);

    // Idle levels after reset
    check_value("up_rack_o", 32'(up_rack), 32'd0);
    check_value("spi_csn_o", 32'(csn), 32'd1);
    check_value("spi_clk_o", 32'(sclk), 32'd0);
    check_value("spi_mosi_o", 32'(mosi), 32'd0);
    check_value("enable_o", 32'(enable), 32'd0);
    check_value("txnrx_o", 32'(txnrx), 32'd0);
    check_pins();
    // The synchronizer picks up the board inputs only after reset release
    repeat (3) @(posedge clk);
    check_gpio_words();
    read_reg(`SYS_ADDR_SPI_STAT, 32'h0, '1, data);

    // GPIO writes, the radio request bits stay low so the FSM rests
    repeat (N_GPIO) begin
      word = $urandom_range(2);
      data = $urandom;
      if (word == 1) begin
        data[16:15] = 2'b00;
      end
      write_reg(8'(word), data);
      gpio_shadow[word*32 +: 32] = data;
      @(negedge clk);
      check_pins();
      check_gpio_words();
    end

    // Board inputs through the synchronizer, and unmapped reads
    repeat (N_PIN) begin
      @(posedge clk);
      bd_in <= 13'($urandom);
      status_in <= 8'($urandom);
      repeat (3) @(posedge clk);
      check_gpio_words();
      do begin
        addr = 8'($urandom);
      end while (addr inside {8'h00, 8'h01, 8'h02, `SYS_ADDR_SPI_DATA, `SYS_ADDR_SPI_STAT});
      read_reg(addr, 32'h0, '1, data);
    end

    // SPI frames, the second write lands while busy and is dropped
    repeat (N_SPI) begin
      frame_word = $urandom;
      write_reg(`SYS_ADDR_SPI_DATA, frame_word);
      @(negedge clk);
      check_value("spi_csn_o", 32'(csn), 32'd0);
      read_reg(`SYS_ADDR_SPI_STAT, 32'h8000_0000, 32'h8000_0000, data);
      write_reg(`SYS_ADDR_SPI_DATA, $urandom);
      polls = 0;
      // Busy and the received byte vary while polling, the bits between them stay zero
      do begin
        read_reg(`SYS_ADDR_SPI_STAT, 32'h0, 32'h7fff_ff00, data);
        polls++;
      end while (data[31] && polls < 2 * `SYS_SPI_FRAME_WIDTH * CLK_DIV);
      assert (!data[31]) else begin
        $display(">>> FAIL");
        $fatal(1, "SPI busy never cleared");
      end
      read_reg(`SYS_ADDR_SPI_STAT, 32'(expected_rx_byte(frame_word[23:0])), '1, data);
      check_value("spi_csn_o", 32'(csn), 32'd1);
    end

    // Radio requests through GPIO bits 47 and 48
    repeat (N_RADIO) begin
      req_en = 1'($urandom);
      req_tx = 1'($urandom);
      word1 = gpio_shadow[63:32];
      word1[15] = req_en;
      word1[16] = req_tx;
      write_reg(`SYS_ADDR_GPIO1, word1);
      gpio_shadow[63:32] = word1;
      waited = 0;
      do begin
        @(negedge clk);
        waited++;
      end while (!(enable == req_en && txnrx == req_tx) && waited < 2 * GUARD + 2);
      check_value("enable_o", 32'(enable), 32'(req_en));
      check_value("txnrx_o", 32'(txnrx), 32'(req_tx));
      check_pins();
      // Let a trailing guard run out before the next request
      repeat (GUARD + 2) @(posedge clk);
    end

    $display(">>> PASS");
    $finish;
  end

endmodule

//--- verification/tb_clkgen.sv
// **********************************************************
// Testbench clock and reset generator
// **********************************************************

`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD       = 10,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic arst_n_o
);

  // Free running clock, first rising edge at half a period
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // Reset held low for the first few rising edges
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

endmodule

//--- source/system_top.sv
// **********************************************************
// Control side top level: register decoder, GPIO bank,
// SPI master and radio enable FSM wired to board pins
// **********************************************************

`timescale 1ns/10ps

module system_top (
  input  logic                  up_clk_i,
  input  logic                  arst_n_i,
  input  system_pkg::up_wr_t    up_wr_i,
  input  system_pkg::up_rd_t    up_rd_i,
  output system_pkg::up_data_t  up_rdata_o,
  output logic                  up_rack_o,
  input  logic [12:0]           gpio_bd_i,
  output logic [7:0]            gpio_bd_o,
  output logic                  gpio_resetb_o,
  output logic                  gpio_sync_o,
  output logic                  gpio_en_agc_o,
  output logic [3:0]            gpio_ctl_o,
  input  logic [7:0]            gpio_status_i,
  output logic                  spi_csn_o,
  output logic                  spi_clk_o,
  output logic                  spi_mosi_o,
  input  logic                  spi_miso_i,
  output logic                  enable_o,
  output logic                  txnrx_o
);

  // Decoder to GPIO bank
  logic [2:0]             gpio_we;
  system_pkg::up_data_t   up_wdata;
  system_pkg::gpio_vec_t  gpio_in;

  // Decoder to and from the SPI master
  logic                   spi_start;
  system_pkg::spi_frame_t spi_frame;
  logic                   spi_busy;
  logic [7:0]             spi_rx;

  // GPIO bits 48:47 carry the host's radio request
  system_pkg::radio_req_t radio_req;

  up_regs i_up_regs (
    .up_clk_i    (up_clk_i),
    .arst_n_i    (arst_n_i),
    .up_wr_i     (up_wr_i),
    .up_rd_i     (up_rd_i),
    .gpio_in_i   (gpio_in),
    .spi_busy_i  (spi_busy),
    .spi_rx_i    (spi_rx),
    .gpio_we_o   (gpio_we),
    .up_wdata_o  (up_wdata),
    .spi_start_o (spi_start),
    .spi_frame_o (spi_frame),
    .up_rdata_o  (up_rdata_o),
    .up_rack_o   (up_rack_o)
  );

  up_gpio i_up_gpio (
    .up_clk_i      (up_clk_i),
    .arst_n_i      (arst_n_i),
    .gpio_we_i     (gpio_we),
    .up_wdata_i    (up_wdata),
    .gpio_bd_i     (gpio_bd_i),
    .gpio_status_i (gpio_status_i),
    .gpio_in_o     (gpio_in),
    .gpio_bd_o     (gpio_bd_o),
    .gpio_resetb_o (gpio_resetb_o),
    .gpio_sync_o   (gpio_sync_o),
    .gpio_en_agc_o (gpio_en_agc_o),
    .gpio_ctl_o    (gpio_ctl_o),
    .radio_req_o   (radio_req)
  );

  up_spi_master #(.CLK_DIV(`SYS_SPI_CLK_DIV)) i_up_spi_master (
    .up_clk_i    (up_clk_i),
    .arst_n_i    (arst_n_i),
    .spi_start_i (spi_start),
    .spi_frame_i (spi_frame),
    .spi_miso_i  (spi_miso_i),
    .spi_busy_o  (spi_busy),
    .spi_rx_o    (spi_rx),
    .spi_csn_o   (spi_csn_o),
    .spi_clk_o   (spi_clk_o),
    .spi_mosi_o  (spi_mosi_o)
  );

  radio_ensm #(.GUARD(`SYS_ENSM_GUARD)) i_radio_ensm (
    .up_clk_i    (up_clk_i),
    .arst_n_i    (arst_n_i),
    .radio_req_i (radio_req),
    .enable_o    (enable_o),
    .txnrx_o     (txnrx_o)
  );

endmodule

//--- radio_ctrl/radio_ensm.sv
// **********************************************************
// Radio enable FSM: enable and txnrx pin sequencing with
// guard time around every txnrx change
// **********************************************************

`timescale 1ns/10ps
`include "system_defines.svh"

module radio_ensm #(
  parameter int GUARD = `SYS_ENSM_GUARD
) (
  input  logic                   up_clk_i,
  input  logic                   arst_n_i,
  input  system_pkg::radio_req_t radio_req_i,
  output logic                   enable_o,
  output logic                   txnrx_o
);

  localparam int GW = (GUARD > 1) ? $clog2(GUARD) : 1;
  localparam logic [GW-1:0] GUARD_LAST = GW'(GUARD - 1);

  system_pkg::ensm_state_e state_q;
  logic [GW-1:0]           guard_cnt_q;
  logic                    guard_done;

  assign guard_done = (guard_cnt_q == GUARD_LAST);

  always_ff @(posedge up_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= system_pkg::OFF;
      guard_cnt_q <= '0;
      enable_o    <= 1'b0;
      txnrx_o     <= 1'b0;
    end else begin
      case (state_q)
        // Enable low, a txnrx change still waits one guard first
        system_pkg::OFF: begin
          guard_cnt_q <= '0;
          if (radio_req_i.txnrx != txnrx_o) begin
            state_q <= system_pkg::FALL_GUARD;
          end else if (radio_req_i.enable) begin
            enable_o <= 1'b1;
            state_q  <= system_pkg::ON;
          end
        end
        // Enable high, drop it before any txnrx change
        system_pkg::ON: begin
          guard_cnt_q <= '0;
          if (radio_req_i.txnrx != txnrx_o) begin
            enable_o <= 1'b0;
            state_q  <= system_pkg::FALL_GUARD;
          end else if (!radio_req_i.enable) begin
            enable_o <= 1'b0;
            state_q  <= system_pkg::OFF;
          end
        end
        // Guard after enable fell, then switch direction
        system_pkg::FALL_GUARD: begin
          guard_cnt_q <= guard_done ? '0 : guard_cnt_q + 1'b1;
          if (guard_done) begin
            txnrx_o <= radio_req_i.txnrx;
            state_q <= system_pkg::SWITCH_GUARD;
          end
        end
        // Guard after the switch, re-enable only if the request still matches
        default: begin
          guard_cnt_q <= guard_done ? '0 : guard_cnt_q + 1'b1;
          if (guard_done) begin
            if (radio_req_i.enable && (radio_req_i.txnrx == txnrx_o)) begin
              enable_o <= 1'b1;
              state_q  <= system_pkg::ON;
            end else begin
              state_q  <= system_pkg::OFF;
            end
          end
        end
      endcase
    end
  end

  // txnrx moves only with enable low before and after the change
  a_txnrx_stable: assert property (@(posedge up_clk_i) disable iff (!arst_n_i)
    $changed(txnrx_o) |-> (!enable_o && !$past(enable_o)));

endmodule

//--- spi/up_spi_master.sv
// **********************************************************
// SPI master for 24-bit transceiver configuration frames,
// mode 0 timing, one chip select
// **********************************************************

`timescale 1ns/10ps
`include "system_defines.svh"

module up_spi_master #(
  parameter int CLK_DIV = `SYS_SPI_CLK_DIV
) (
  input  logic                   up_clk_i,
  input  logic                   arst_n_i,
  input  logic                   spi_start_i,
  input  system_pkg::spi_frame_t spi_frame_i,
  input  logic                   spi_miso_i,
  output logic                   spi_busy_o,
  output logic [7:0]             spi_rx_o,
  output logic                   spi_csn_o,
  output logic                   spi_clk_o,
  output logic                   spi_mosi_o
);

  localparam int FRAME_W = `SYS_SPI_FRAME_WIDTH;
  localparam int DIV_W   = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
  localparam int BIT_W   = $clog2(FRAME_W + 1);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(CLK_DIV - 1);
  localparam logic [BIT_W-1:0] BIT_END  = BIT_W'(FRAME_W);

  logic [DIV_W-1:0]       div_cnt_q;
  logic [BIT_W-1:0]       bit_cnt_q;
  logic                   busy_q;
  logic                   csn_q;
  logic                   sclk_q;
  logic                   tick;
  system_pkg::spi_frame_t tx_sreg_q;
  logic [7:0]             rx_sreg_q;
  logic [7:0]             rx_byte_q;

  // Serial clock edge due on this cycle, only while bits remain
  assign tick = busy_q && (bit_cnt_q != BIT_END) && (div_cnt_q == DIV_LAST);

  // **********************************************************
  // Frame control: divider, bit counter, busy and chip select
  // **********************************************************
  always_ff @(posedge up_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q    <= 1'b0;
      csn_q     <= 1'b1;
      sclk_q    <= 1'b0;
      div_cnt_q <= '0;
      bit_cnt_q <= '0;
      rx_byte_q <= '0;
    end else if (!busy_q) begin
      if (spi_start_i) begin
        busy_q    <= 1'b1;
        csn_q     <= 1'b0;
        div_cnt_q <= '0;
        bit_cnt_q <= '0;
      end
    end else if (bit_cnt_q == BIT_END) begin
      // One cycle after the last falling edge the frame closes
      busy_q    <= 1'b0;
      csn_q     <= 1'b1;
      rx_byte_q <= rx_sreg_q;
    end else if (tick) begin
      div_cnt_q <= '0;
      sclk_q    <= !sclk_q;
      // A falling edge completes one bit
      if (sclk_q) begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      div_cnt_q <= div_cnt_q + 1'b1;
    end
  end

  // Shift registers, MSB first out, sample on rising edges
  always_ff @(posedge up_clk_i) begin
    if (!busy_q && spi_start_i) begin
      tx_sreg_q <= spi_frame_i;
    end else if (tick) begin
      if (sclk_q) begin
        tx_sreg_q <= {tx_sreg_q[FRAME_W-2:0], 1'b0};
      end else begin
        rx_sreg_q <= {rx_sreg_q[6:0], spi_miso_i};
      end
    end
  end

  assign spi_busy_o = busy_q;
  assign spi_csn_o  = csn_q;
  assign spi_clk_o  = sclk_q;
  // mosi held low between frames
  assign spi_mosi_o = !csn_q && tx_sreg_q[FRAME_W-1];
  assign spi_rx_o   = rx_byte_q;

  // Serial clock pulses only happen inside a selected frame
  a_sclk_in_frame: assert property (@(posedge up_clk_i) disable iff (!arst_n_i)
    spi_clk_o |-> !spi_csn_o);

endmodule

//--- gpio/up_gpio.sv
// **********************************************************
// GPIO bank: 96-bit output register, input synchronizer
// and the readable vector with pin inputs and loopback
// **********************************************************

`timescale 1ns/10ps
`include "system_defines.svh"

module up_gpio (
  input  logic                   up_clk_i,
  input  logic                   arst_n_i,
  input  logic [2:0]             gpio_we_i,
  input  system_pkg::up_data_t   up_wdata_i,
  input  logic [12:0]            gpio_bd_i,
  input  logic [7:0]             gpio_status_i,
  output system_pkg::gpio_vec_t  gpio_in_o,
  output logic [7:0]             gpio_bd_o,
  output logic                   gpio_resetb_o,
  output logic                   gpio_sync_o,
  output logic                   gpio_en_agc_o,
  output logic [3:0]             gpio_ctl_o,
  output system_pkg::radio_req_t radio_req_o
);

  system_pkg::gpio_vec_t gpio_out_q;
  // Status pins in the upper 8 bits, board inputs in the lower 13
  logic [20:0]           sync_q1;
  logic [20:0]           sync_q2;

  // Output register, written one 32-bit word at a time
  always_ff @(posedge up_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
    end else begin
      for (int w = 0; w < 3; w++) begin
        if (gpio_we_i[w]) begin
          gpio_out_q[w*`SYS_DATA_WIDTH +: `SYS_DATA_WIDTH] <= up_wdata_i;
        end
      end
    end
  end

  // Two flop synchronizer for the asynchronous board inputs
  always_ff @(posedge up_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= {gpio_status_i, gpio_bd_i};
      sync_q2 <= sync_q1;
    end
  end

  // Readable vector, pins on 39:32 and 12:0, loopback elsewhere
  assign gpio_in_o = {gpio_out_q[95:40], sync_q2[20:13], gpio_out_q[31:13], sync_q2[12:0]};

  // Board outputs straight from the register
  assign gpio_resetb_o = gpio_out_q[46];
  assign gpio_sync_o   = gpio_out_q[45];
  assign gpio_en_agc_o = gpio_out_q[44];
  assign gpio_ctl_o    = gpio_out_q[43:40];
  assign gpio_bd_o     = gpio_out_q[20:13];
  assign radio_req_o   = system_pkg::radio_req_t'(gpio_out_q[48:47]);

  // The decoder selects one word per write
  a_one_word_we: assert property (@(posedge up_clk_i) disable iff (!arst_n_i)
    $onehot0(gpio_we_i));

endmodule

//--- source/up_regs.sv
// **********************************************************
// Register port decoder: GPIO word enables, SPI start,
// registered read data and read acknowledge
// **********************************************************

`timescale 1ns/10ps
`include "system_defines.svh"

module up_regs (
  input  logic                   up_clk_i,
  input  logic                   arst_n_i,
  input  system_pkg::up_wr_t     up_wr_i,
  input  system_pkg::up_rd_t     up_rd_i,
  input  system_pkg::gpio_vec_t  gpio_in_i,
  input  logic                   spi_busy_i,
  input  logic [7:0]             spi_rx_i,
  output logic [2:0]             gpio_we_o,
  output system_pkg::up_data_t   up_wdata_o,
  output logic                   spi_start_o,
  output system_pkg::spi_frame_t spi_frame_o,
  output system_pkg::up_data_t   up_rdata_o,
  output logic                   up_rack_o
);

  system_pkg::up_data_t rdata_mux;

  // Write decode is combinational so targets load on the strobe's edge
  assign gpio_we_o[0] = up_wr_i.req && (up_wr_i.addr == `SYS_ADDR_GPIO0);
  assign gpio_we_o[1] = up_wr_i.req && (up_wr_i.addr == `SYS_ADDR_GPIO1);
  assign gpio_we_o[2] = up_wr_i.req && (up_wr_i.addr == `SYS_ADDR_GPIO2);
  assign up_wdata_o   = up_wr_i.data;

  // A frame write while the master is busy is dropped here
  assign spi_start_o = up_wr_i.req && !spi_busy_i &&
                       (up_wr_i.addr == `SYS_ADDR_SPI_DATA);
  assign spi_frame_o = up_wr_i.data[`SYS_SPI_FRAME_WIDTH-1:0];

  // Read select, unmapped addresses give zero
  always_comb begin
    case (up_rd_i.addr)
      `SYS_ADDR_GPIO0:    rdata_mux = gpio_in_i[31:0];
      `SYS_ADDR_GPIO1:    rdata_mux = gpio_in_i[63:32];
      `SYS_ADDR_GPIO2:    rdata_mux = gpio_in_i[95:64];
      `SYS_ADDR_SPI_STAT: rdata_mux = {spi_busy_i, {(`SYS_DATA_WIDTH-9){1'b0}}, spi_rx_i};
      default:            rdata_mux = '0;
    endcase
  end

  // Acknowledge is the strobe delayed by one cycle
  always_ff @(posedge up_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      up_rack_o <= 1'b0;
    end else begin
      up_rack_o <= up_rd_i.req;
    end
  end

  // Data only loads on a read so it stays stable between requests
  always_ff @(posedge up_clk_i) begin
    if (up_rd_i.req) begin
      up_rdata_o <= rdata_mux;
    end
  end

  // A read strobe lasts one cycle so every read gets exactly one acknowledge
  a_read_single_pulse: assert property (@(posedge up_clk_i) disable iff (!arst_n_i)
    up_rd_i.req |=> !up_rd_i.req);

endmodule

//--- common/system_pkg.sv
// **********************************************************
// Shared types: register port structs, GPIO and SPI
// vectors, radio request and enable FSM states
// **********************************************************

`include "system_defines.svh"

package system_pkg;

  typedef logic [`SYS_ADDR_WIDTH-1:0]      up_addr_t;
  typedef logic [`SYS_DATA_WIDTH-1:0]      up_data_t;
  typedef logic [`SYS_GPIO_WIDTH-1:0]      gpio_vec_t;
  typedef logic [`SYS_SPI_FRAME_WIDTH-1:0] spi_frame_t;

  // Host write request, req is a single cycle strobe
  typedef struct packed {
    logic     req;
    up_addr_t addr;
    up_data_t data;
  } up_wr_t;

  // Host read request, acknowledged one cycle later
  typedef struct packed {
    logic     req;
    up_addr_t addr;
  } up_rd_t;

  // Packed in GPIO bit order, txnrx on bit 48 and enable on bit 47
  typedef struct packed {
    logic txnrx;
    logic enable;
  } radio_req_t;

  typedef enum logic [1:0] {OFF, ON, FALL_GUARD, SWITCH_GUARD} ensm_state_e;

endpackage

//--- common/system_defines.svh
// **********************************************************
// Register map, widths and timing constants of the
// transceiver control side
// **********************************************************

`ifndef SYSTEM_DEFINES_SVH
`define SYSTEM_DEFINES_SVH

// Data path widths
`define SYS_GPIO_WIDTH      96
`define SYS_DATA_WIDTH      32
`define SYS_ADDR_WIDTH      8

// Word addresses of the register port
`define SYS_ADDR_GPIO0      8'h00
`define SYS_ADDR_GPIO1      8'h01
`define SYS_ADDR_GPIO2      8'h02
`define SYS_ADDR_SPI_DATA   8'h10
`define SYS_ADDR_SPI_STAT   8'h11

// SPI frame length and serial clock half-period in up_clk cycles
`define SYS_SPI_FRAME_WIDTH 24
`define SYS_SPI_CLK_DIV     4

// Cycles kept on both sides of a txnrx change
`define SYS_ENSM_GUARD      8

`endif
